// File: organ_top.f
+incdir+.
organ_pkg.sv
voice_if.sv
mode_controller.sv
note_sequencer.sv
tone_voice.sv
voice_mixer.sv
organ_top.sv
tb_clock_gen.sv
organ_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the organ core testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -f organ_top.f \
    --top-module organ_top_tb -o organ_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/organ_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: organ_top_tb_tasks.svh
/*
 * testbench compare tasks, one per result type
 * polling waits on voice_active and mode_switch, each with a cycle limit
 */
`ifndef ORGAN_TOP_TB_TASKS_SVH
`define ORGAN_TOP_TB_TASKS_SVH

task automatic check_mask(input string name, input voice_mask_t exp, input voice_mask_t act);
    if (act !== exp)
        fail_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
endtask

task automatic check_note(input string name, input note_t exp, input note_t act);
    if (act !== exp)
        fail_run($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic check_level(input string name, input level_t exp, input level_t act);
    if (act !== exp)
        fail_run($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic check_mode(input string name, input logic exp, input logic act);
    if (act !== exp)
        fail_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
endtask

task automatic check_led(input string name, input led_t exp, input led_t act);
    if (act !== exp)
        fail_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
endtask

task automatic check_ind(input string name, input ind_t exp, input ind_t act);
    if (act !== exp)
        fail_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
endtask

// durations and half periods in clock cycles
task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp)
        fail_run($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
endtask

task automatic wait_mask(input string name, input voice_mask_t exp, input int limit);
    int n;
    for (n = 0; n < limit && voice_active !== exp; n++)
        @(negedge clk);
    if (voice_active !== exp)
        fail_run($sformatf("timeout in %s: voice_active did not become %b in %0d cycles",
                           name, exp, limit));
endtask

task automatic wait_switch(input int limit);
    int n;
    for (n = 0; n < limit && mode_switch !== 1'b1; n++)
        @(negedge clk);
    if (mode_switch !== 1'b1)
        fail_run($sformatf("timeout: no mode_switch pulse within %0d cycles of the key", limit));
endtask

`endif

// File: organ_top_tb.sv
/*
 * organ core testbench
 * stimulus table of manual and auto rows, applied in a loop
 * mode toggle, note length, pitch, pwm duty, melody and abort checks
 */
`include "organ_settings.svh"

module organ_top_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import organ_pkg::*;

    typedef struct {
        string       name;
        logic        mode;    // 0 manual, 1 auto
        key_vec_t    keys;
        voice_mask_t mask;    // voices expected busy
        note_t       note;    // first note expected on the display
    } row_t;

    logic        clk, rst_n, mode_key, current_mode, mode_switch, audio_pwm;
    key_vec_t    key_pulse;
    led_t        led_display;
    ind_t        mode_indicator;
    voice_mask_t voice_active;
    level_t      audio_level;
    note_t       note_display;
    row_t        stim_rows[$];

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    organ_top UUT (
        .clk(clk), .rst_n(rst_n), .mode_key(mode_key), .key_pulse(key_pulse),
        .current_mode(current_mode), .mode_switch(mode_switch),
        .led_display(led_display), .mode_indicator(mode_indicator),
        .voice_active(voice_active), .audio_level(audio_level),
        .audio_pwm(audio_pwm), .note_display(note_display)
    );

    `include "organ_top_tb_tasks.svh"

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int ones_in(input voice_mask_t m);
        int c;
        c = 0;
        for (int v = 0; v < `ORGAN_VOICES; v++)
            c += int'(m[v]);
        return c;
    endfunction

    task automatic pulse_keys(input key_vec_t keys);
        @(negedge clk);
        key_pulse = keys;   // one cycle pulse
        @(negedge clk);
        key_pulse = '0;
    endtask

    // press edge flips mode within 4 cycles, leds one cycle later
    task automatic press_mode(input logic exp);
        @(negedge clk);
        mode_key = 1'b0;
        wait_switch(4);
        check_mode("mode toggle", exp, current_mode);
        @(negedge clk);
        check_mode("mode_switch width", 1'b0, mode_switch);
        check_led("mode leds", exp ? 8'b1111_1101 : 8'b1111_1110, led_display);
        check_ind("mode indicator", exp ? 4'b1101 : 4'b1110, mode_indicator);
        mode_key = 1'b1;
        repeat (4) @(negedge clk);   // release through the synchroniser
    endtask

    task automatic run_manual(input row_t r);
        int         count;
        int         last_change;
        int         half;
        level_t     last_level;
        level_t     exp_level;
        logic [3:0] pwm_win;   // last four pwm samples
        half = `ORGAN_BASE_HALF - int'(r.note) * `ORGAN_STEP_HALF;   // linear tone rule
        pulse_keys(r.keys);
        wait_mask(r.name, r.mask, 10);
        check_note(r.name, r.note, note_display);
        count       = 1;
        last_change = 1;
        last_level  = audio_level;
        pwm_win     = {3'b000, audio_pwm};
        while (voice_active === r.mask && count <= `ORGAN_NOTE_CYCLES + 10) begin
            @(negedge clk);
            if (voice_active === r.mask) begin
                count++;
                pwm_win = {pwm_win[2:0], audio_pwm};
                // a full 2-bit frame over a steady level gives level high samples
                if (ones_in(r.mask) == 1 && count >= 5
                        && (count - 5) / half == (count - 2) / half) begin
                    exp_level = level_t'(((count - 2) / half) % 2 == 0);  // high in even halves
                    check_level({r.name, " pwm duty"}, exp_level,
                                level_t'($countones(pwm_win)));
                end
                if (audio_level > level_t'(ones_in(voice_active)))   // above active voices
                    check_level({r.name, " level bound"}, level_t'(ones_in(voice_active)),
                                audio_level);
                if (audio_level !== last_level) begin
                    if (ones_in(r.mask) == 1)   // pitch only readable with one voice
                        check_cycles({r.name, " half period"}, half, count - last_change);
                    last_change = count;
                    last_level  = audio_level;
                end
            end
        end
        check_cycles({r.name, " note length"}, `ORGAN_NOTE_CYCLES, count);
        check_mask({r.name, " release"}, '0, voice_active);
    endtask

    // note i of melody k is (k + 3i) mod 16, all on voice 0
    task automatic run_auto(input row_t r);
        int i;
        pulse_keys(r.keys);
        for (i = 0; i < `ORGAN_MELODY_LEN; i++) begin
            wait_mask(r.name, r.mask, 10);
            check_note($sformatf("%s note %0d", r.name, i),
                       note_t'((int'(r.note) + 3 * i) % 16), note_display);
            wait_mask(r.name, '0, `ORGAN_NOTE_CYCLES + 10);
        end
        repeat (30) begin   // melody over, stays silent
            @(negedge clk);
            check_mask({r.name, " melody end"}, '0, voice_active);
        end
    endtask

    task automatic abort_melody;
        press_mode(1'b1);
        pulse_keys(16'h0040);
        wait_mask("abort start", 4'b0001, 10);
        repeat (20) @(negedge clk);
        press_mode(1'b0);                   // switch pulse stops the voices
        wait_mask("abort stop", '0, 10);
        repeat (20) begin
            @(negedge clk);
            check_mask("abort silent", '0, voice_active);
        end
    endtask

    initial begin
        int n;
        mode_key  = 1'b1;   // idle high
        key_pulse = '0;
        void'($urandom(39965));
        stim_rows.push_back(row_t'{"man_k0",    1'b0, 16'h0001, 4'b0001, 4'd0});
        stim_rows.push_back(row_t'{"man_k5",    1'b0, 16'h0020, 4'b0010, 4'd5});
        stim_rows.push_back(row_t'{"man_k10",   1'b0, 16'h0400, 4'b0100, 4'd10});
        stim_rows.push_back(row_t'{"man_k15",   1'b0, 16'h8000, 4'b1000, 4'd15});
        stim_rows.push_back(row_t'{"man_chord", 1'b0, 16'h084A, 4'b1110, 4'd11});
        stim_rows.push_back(row_t'{"auto_k2",   1'b1, 16'h0004, 4'b0001, 4'd2});
        stim_rows.push_back(row_t'{"auto_k9",   1'b1, 16'h0200, 4'b0001, 4'd9});
        stim_rows.push_back(row_t'{"auto_low",  1'b1, 16'h2010, 4'b0001, 4'd4});
        stim_rows.push_back(row_t'{"man_k7",    1'b0, 16'h0080, 4'b1000, 4'd7});

        for (n = 0; n < 20 && rst_n !== 1'b1; n++)
            @(negedge clk);
        if (rst_n !== 1'b1)
            fail_run("timeout: reset was never released");
        @(negedge clk);
        check_mode("reset mode", 1'b0, current_mode);
        check_mode("reset mode_switch", 1'b0, mode_switch);
        check_mode("reset pwm", 1'b0, audio_pwm);
        check_led("reset leds", 8'b1111_1110, led_display);
        check_ind("reset indicator", 4'b1110, mode_indicator);
        check_mask("reset voices", '0, voice_active);

        foreach (stim_rows[i]) begin
            if (stim_rows[i].mode !== current_mode)
                press_mode(stim_rows[i].mode);
            if (stim_rows[i].mode)
                run_auto(stim_rows[i]);
            else
                run_manual(stim_rows[i]);
            repeat ($urandom % 8 + 1) @(negedge clk);   // random idle gap
        end
        abort_melody();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
/*
 * testbench clock and reset
 * 4 ns clock, reset low for the first 3 cycles
 */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;            // release away from the active edge
    end

endmodule

// File: organ_top.sv
/*
 * organ core top level
 * mode controller, note sequencer, voice array, mixer
 */
`include "organ_settings.svh"

module organ_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mode_key,
    input  organ_pkg::key_vec_t     key_pulse,
    output logic                    current_mode,
    output logic                    mode_switch,
    output organ_pkg::led_t         led_display,
    output organ_pkg::ind_t         mode_indicator,
    output organ_pkg::voice_mask_t  voice_active,
    output organ_pkg::level_t       audio_level,
    output logic                    audio_pwm,
    output organ_pkg::note_t        note_display
);

    voice_if vif [`ORGAN_VOICES] ();   // one link per voice

    mode_controller u_mode (
        .clk            (clk),
        .rst_n          (rst_n),
        .mode_key       (mode_key),
        .current_mode   (current_mode),
        .mode_switch    (mode_switch),
        .led_display    (led_display),
        .mode_indicator (mode_indicator)
    );

    note_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_pulse    (key_pulse),
        .current_mode (current_mode),
        .mode_switch  (mode_switch),
        .vif          (vif),
        .note_display (note_display)
    );

    // identical voices
    for (genvar g = 0; g < `ORGAN_VOICES; g++) begin : g_voice
        tone_voice u_voice (
            .clk   (clk),
            .rst_n (rst_n),
            .vif   (vif[g])
        );
    end

    voice_mixer u_mix (
        .clk          (clk),
        .rst_n        (rst_n),
        .vif          (vif),
        .voice_active (voice_active),
        .audio_level  (audio_level),
        .audio_pwm    (audio_pwm)
    );

endmodule

// File: voice_mixer.sv
/*
 * voice mixer
 * registered busy mask and count of high tones
 * 2-bit frame PWM from the level
 */
`include "organ_settings.svh"

module voice_mixer (
    input  logic                    clk,
    input  logic                    rst_n,
    voice_if.mixer                  vif [`ORGAN_VOICES],
    output organ_pkg::voice_mask_t  voice_active,
    output organ_pkg::level_t       audio_level,
    output logic                    audio_pwm
);
    import organ_pkg::*;

    voice_mask_t busy_v;
    voice_mask_t tone_v;
    level_t      tone_count;
    logic [1:0]  frame;        // free running

    for (genvar g = 0; g < `ORGAN_VOICES; g++) begin : g_tap
        assign busy_v[g] = vif[g].busy;
        assign tone_v[g] = vif[g].tone;
    end

    // popcount of tones
    always_comb begin
        tone_count = '0;
        for (int v = 0; v < `ORGAN_VOICES; v++)
            tone_count = tone_count + level_t'(tone_v[v]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            voice_active <= '0;
            audio_level  <= '0;
            frame        <= '0;
            audio_pwm    <= 1'b0;
        end else begin
            voice_active <= busy_v;
            audio_level  <= tone_count;            // one cycle behind tones
            frame        <= frame + 2'd1;
            audio_pwm    <= ({1'b0, frame} < audio_level);  // duty = level/4
        end
    end

endmodule

// File: tone_voice.sv
/*
 * one square wave voice
 * fixed-length busy window after each load
 * tone toggles every half period while busy
 */
`include "organ_settings.svh"

module tone_voice (
    input  logic    clk,
    input  logic    rst_n,
    voice_if.voice  vif
);
    import organ_pkg::*;

    localparam int DUR_W = $clog2(`ORGAN_NOTE_CYCLES);

    logic [DUR_W-1:0] dur_cnt;    // cycles left in the note
    half_period_t     half_len;   // latched with load
    half_period_t     half_cnt;   // cycles left in this half
    logic             busy_r;
    logic             tone_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dur_cnt  <= '0;
            half_cnt <= '0;
            busy_r   <= 1'b0;
            tone_r   <= 1'b0;
        end else if (vif.stop) begin
            busy_r <= 1'b0;
            tone_r <= 1'b0;
        end else if (vif.load) begin           // restarts a busy voice too
            busy_r   <= 1'b1;
            tone_r   <= 1'b1;                  // high with busy
            dur_cnt  <= DUR_W'(`ORGAN_NOTE_CYCLES - 1);
            half_cnt <= vif.half_period - 8'd1;
        end else if (busy_r) begin
            if (dur_cnt == '0) begin           // note over
                busy_r <= 1'b0;
                tone_r <= 1'b0;
            end else begin
                dur_cnt <= dur_cnt - 1'b1;
                if (half_cnt == '0) begin
                    tone_r   <= ~tone_r;
                    half_cnt <= half_len - 8'd1;
                end else begin
                    half_cnt <= half_cnt - 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk)
        if (vif.load)
            half_len <= vif.half_period;

    assign vif.busy = busy_r;
    assign vif.tone = tone_r;

endmodule

// File: note_sequencer.sv
/*
 * note sequencer
 * manual mode: key pulses to per-voice loads
 * auto mode: melody playback FSM on voice 0
 */
`include "organ_settings.svh"

module note_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  organ_pkg::key_vec_t  key_pulse,
    input  logic                 current_mode,   // 0 manual, 1 auto
    input  logic                 mode_switch,
    voice_if.sequencer           vif [`ORGAN_VOICES],
    output organ_pkg::note_t     note_display    // last note loaded
);
    import organ_pkg::*;

    localparam int STEP_W = $clog2(`ORGAN_MELODY_LEN + 1);

    voice_mask_t       load_r;
    voice_mask_t       stop_r;
    half_period_t      half_r [`ORGAN_VOICES];   // payload, no reset
    seq_state_t        state;
    note_t             melody;                   // melody index = start key
    logic [STEP_W-1:0] step;                     // notes loaded so far
    logic              voice0_busy;

    voice_mask_t man_hit;                        // voices hit this cycle
    note_t       man_note [`ORGAN_VOICES];       // winning key per voice
    note_t       man_last;                       // highest key overall
    note_t       first_key;                      // lowest key, picks melody
    note_t       gap_note;                       // next melody note

    function automatic half_period_t half_of(input note_t n);
        return half_period_t'(`ORGAN_HALF_OF(n));
    endfunction

    // note i of melody k is (k + 3i) mod 16
    function automatic note_t melody_note(input note_t k, input logic [STEP_W-1:0] i);
        logic [7:0] sum;
        sum = 8'(k) + 8'(i) * 8'(`ORGAN_MELODY_STEP);
        return sum[3:0];
    endfunction

    // manual decode, ascending scan so highest key wins per voice
    always_comb begin
        man_hit  = '0;
        man_last = '0;
        for (int v = 0; v < `ORGAN_VOICES; v++)
            man_note[v] = '0;
        for (int k = 0; k < 16; k++) begin
            if (key_pulse[k]) begin
                man_hit[k % `ORGAN_VOICES]  = 1'b1;
                man_note[k % `ORGAN_VOICES] = note_t'(k);
                man_last                    = note_t'(k);
            end
        end
    end

    // descending scan, lowest set key is left
    always_comb begin
        first_key = '0;
        for (int k = 15; k >= 0; k--)
            if (key_pulse[k])
                first_key = note_t'(k);
    end

    assign gap_note = melody_note(melody, step);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_r       <= '0;
            stop_r       <= '0;
            state        <= IDLE;
            melody       <= '0;
            step         <= '0;
            note_display <= '0;
        end else begin
            load_r <= '0;   // pulses
            stop_r <= '0;
            if (mode_switch) begin
                stop_r <= '1;       // silence everything
                state  <= IDLE;
            end else if (!current_mode) begin
                load_r <= man_hit;
                if (|man_hit)
                    note_display <= man_last;
            end else if (|key_pulse) begin
                melody       <= first_key;   // start or restart melody
                step         <= STEP_W'(1);
                load_r[0]    <= 1'b1;        // note 0 is the key itself
                note_display <= first_key;
                state        <= PLAY;
            end else begin
                case (state)
                    PLAY: if (!load_r[0] && !voice0_busy)   // note done
                        state <= (step == STEP_W'(`ORGAN_MELODY_LEN)) ? IDLE : GAP;
                    GAP: begin
                        load_r[0]    <= 1'b1;
                        note_display <= gap_note;
                        step         <= step + 1'b1;
                        state        <= PLAY;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // half periods ride along with the loads above
    always_ff @(posedge clk) begin
        for (int v = 0; v < `ORGAN_VOICES; v++)
            if (!current_mode && man_hit[v])
                half_r[v] <= half_of(man_note[v]);
        if (current_mode && |key_pulse)
            half_r[0] <= half_of(first_key);
        else if (current_mode && state == GAP)
            half_r[0] <= half_of(gap_note);
    end

    for (genvar g = 0; g < `ORGAN_VOICES; g++) begin : g_drive
        assign vif[g].load        = load_r[g];
        assign vif[g].stop        = stop_r[g];
        assign vif[g].half_period = half_r[g];
    end

    assign voice0_busy = vif[0].busy;   // melodies only use voice 0

endmodule

// File: mode_controller.sv
/*
 * mode key synchroniser and falling edge detect
 * manual/auto mode toggle with one-cycle switch pulse
 * registered active-low mode LEDs
 */
module mode_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mode_key,       // idle high, low when pressed
    output logic              current_mode,   // 0 manual, 1 auto
    output logic              mode_switch,
    output organ_pkg::led_t   led_display,
    output organ_pkg::ind_t   mode_indicator
);
    import organ_pkg::*;

    localparam led_t LED_MANUAL = 8'b1111_1110;  // led 1 lit
    localparam led_t LED_AUTO   = 8'b1111_1101;  // led 2 lit
    localparam ind_t IND_MANUAL = 4'b1110;
    localparam ind_t IND_AUTO   = 4'b1101;

    logic key_meta;   // first sync stage
    logic key_sync;   // second sync stage
    logic key_prev;   // edge detect delay
    logic key_fall;

    // sync flops start at the idle level, so no false press out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
            key_prev <= 1'b1;
        end else begin
            key_meta <= mode_key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    assign key_fall = key_prev & ~key_sync;  // press edge

    // flip on the third edge after the key falls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_mode <= 1'b0;       // manual
            mode_switch  <= 1'b0;
        end else begin
            mode_switch <= key_fall;    // one cycle
            if (key_fall)
                current_mode <= ~current_mode;
        end
    end

    // leds lag the mode by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_display    <= LED_MANUAL;
            mode_indicator <= IND_MANUAL;
        end else begin
            led_display    <= current_mode ? LED_AUTO : LED_MANUAL;
            mode_indicator <= current_mode ? IND_AUTO : IND_MANUAL;
        end
    end

endmodule

// File: voice_if.sv
/*
 * per-voice link
 * load/stop commands and half period in, busy and tone out
 * modports for sequencer, voice and mixer
 */
interface voice_if;
    import organ_pkg::*;

    logic         load;          // start or restart note
    logic         stop;          // silence now
    half_period_t half_period;   // valid with load
    logic         busy;          // note in progress
    logic         tone;          // square wave

    modport sequencer (
        output load, stop, half_period,
        input  busy
    );

    modport voice (
        input  load, stop, half_period,
        output busy, tone
    );

    modport mixer (input busy, tone);

endinterface

// File: organ_pkg.sv
/*
 * organ core types
 * key, note, period, voice mask, level and LED vectors
 * auto playback FSM state enum
 */
`include "organ_settings.svh"

package organ_pkg;

    // one bit per matrix key, index = row*4 + col
    typedef logic [15:0] key_vec_t;

    typedef logic [3:0] note_t;          // note 0..15
    typedef logic [7:0] half_period_t;   // cycles per tone half

    typedef logic [`ORGAN_VOICES-1:0] voice_mask_t; // one bit per voice

    // count of high tones, up to 4 voices
    typedef logic [2:0] level_t;

    typedef logic [7:0] led_t;   // active low
    typedef logic [3:0] ind_t;   // active low

    // auto playback
    typedef enum logic [1:0] {
        IDLE,   // no melody
        PLAY,   // note sounding
        GAP     // one cycle between notes
    } seq_state_t;

endpackage

// File: organ_settings.svh
/*
 * organ core build constants
 * voice count, note and melody lengths, linear tone rule
 */
`ifndef ORGAN_SETTINGS_SVH
`define ORGAN_SETTINGS_SVH

`define ORGAN_VOICES      4     // square wave voices
`define ORGAN_NOTE_CYCLES 200   // busy time per note
`define ORGAN_MELODY_LEN  8     // notes per melody

// linear pitch, not a musical scale
`define ORGAN_BASE_HALF   48    // half period of note 0
`define ORGAN_STEP_HALF   2     // drop per note step
`define ORGAN_MELODY_STEP 3     // note increment inside a melody

// half period of note n
`define ORGAN_HALF_OF(n) (`ORGAN_BASE_HALF - (n) * `ORGAN_STEP_HALF)

`endif
